/* compile.f */
verilog/debounce_pkg.sv
verilog/event_cfg_if.sv
verilog/debounce_bank.sv
verilog/wb_reg_slave.sv
verilog/edge_event_unit.sv
verilog/debounce_top.sv
verif/debounce_assertions.sv
verif/debounce_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module debounce_tb -o sim_debounce

./obj_dir/sim_debounce +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    exit 1
fi
exit 0

/* verif/debounce_tb.sv */
// Runs debounce_top with NUM_INPUTS 8 and STABLE_COUNT 8; the glitch test needs STABLE_COUNT >= 4
module debounce_tb;

    localparam int NUM_INPUTS      = 8;
    localparam int STABLE_COUNT    = 8;
    localparam int DW              = debounce_pkg::data_width;
    localparam int AW              = debounce_pkg::addr_width;
    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 3;
    localparam int ACK_LIMIT       = 8;
    localparam int NUM_PULSES      = 8;
    localparam int GLITCH_READS    = STABLE_COUNT / 2 + 4;
    localparam int SETTLE_MIN      = STABLE_COUNT / 2;
    localparam int SETTLE_MAX      = 2 + STABLE_COUNT / 2 + 2;
    localparam int SATURATE        = 2 + STABLE_COUNT + 4; // Every counter reaches a rail
    localparam int HOLD_CYCLES     = 6;
    localparam int SETTLE_CYCLES   = 2 * (SETTLE_MAX + 2) + STABLE_COUNT + 2;
    localparam int GLITCH_CYCLES   = 2 * SATURATE
                                   + 2 * NUM_PULSES * (STABLE_COUNT / 2 + 2 * GLITCH_READS);
    localparam int RUN_CYCLES      = RESET_CYCLES + GLITCH_CYCLES + 3 * SETTLE_CYCLES
                                   + 3 * 16 + HOLD_CYCLES;
    localparam int WATCHDOG_MARGIN = 100;
    localparam int WATCHDOG_TIME   = (RUN_CYCLES + WATCHDOG_MARGIN) * CLK_PERIOD;
    localparam logic [NUM_INPUTS-1:0] RISE_MASK = NUM_INPUTS'('h0f);
    localparam logic [NUM_INPUTS-1:0] FALL_MASK = NUM_INPUTS'('h3c);
    localparam logic [NUM_INPUTS-1:0] KEEP_BIT  = NUM_INPUTS'('h08); // Set in both masks

    logic                  clk;
    logic                  reset;
    logic [NUM_INPUTS-1:0] raw_in;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [AW-1:0]         wb_adr;
    logic [DW-1:0]         wb_dat_w;
    logic [DW-1:0]         wb_dat_r;
    logic                  wb_ack;
    logic                  irq;

    integer                seed;
    int                    errors = 0;
    int                    passed = 0;
    int                    failed = 0;
    int                    test_base;
    logic [NUM_INPUTS-1:0] level_model;   // Debounced level the inputs were last settled at
    logic [NUM_INPUTS-1:0] pending_model;

    debounce_top #(
        .NUM_INPUTS   (NUM_INPUTS),
        .STABLE_COUNT (STABLE_COUNT)
    ) DUT (
        .clk      (clk),
        .reset    (reset),
        .raw_in   (raw_in),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .irq      (irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired after %0d cycles, the run did not finish",
                 RUN_CYCLES + WATCHDOG_MARGIN);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    function automatic int failure_total();
        return errors + DUT.u_checks.fail_count;
    endfunction

    function automatic logic [DW-1:0] widen(input logic [NUM_INPUTS-1:0] bits);
        logic [DW-1:0] word;
        word = '0;
        word[NUM_INPUTS-1:0] = bits;
        return word;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // Called 1 unit after a rising edge, returns 1 unit after the edge that saw ack
    task automatic bus_access(input logic we, input logic [AW-1:0] adr,
                              input logic [DW-1:0] wdata, output logic [DW-1:0] rdata);
        int waited;
        waited   = 0;
        rdata    = '0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        do begin
            @(posedge clk);
            waited++;
        end while (!wb_ack && waited < ACK_LIMIT);
        if (wb_ack) begin
            rdata = wb_dat_r;
        end else begin
            $display("bus access to register %0d got no ack within %0d cycles", adr, ACK_LIMIT);
            errors++;
        end
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_read(input logic [AW-1:0] adr, output logic [DW-1:0] rdata);
        bus_access(1'b0, adr, '0, rdata);
    endtask

    task automatic bus_write(input logic [AW-1:0] adr, input logic [DW-1:0] wdata);
        logic [DW-1:0] unused_rd;
        bus_access(1'b1, adr, wdata, unused_rd);
    endtask

    task automatic check_word(input string what, input logic [DW-1:0] got,
                              input logic [DW-1:0] exp);
        assert (got === exp) else begin
            $display("FAIL %0t: %s read 0x%0h, expected 0x%0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_irq(input logic exp);
        @(posedge clk);
        assert (irq === exp) else begin
            $display("FAIL %0t: irq is %b, expected %b", $time, irq, exp);
            errors++;
        end
        #1;
    endtask

    task automatic start_test();
        test_base = failure_total();
    endtask

    task automatic end_test(input string name);
        if (failure_total() == test_base) begin
            passed++;
            $display("test %s: PASS", name);
        end else begin
            failed++;
            $display("test %s: FAIL", name);
        end
    endtask

    // Polls reg_level after a steady change and checks when the new level shows up
    task automatic measure_settle(input logic [NUM_INPUTS-1:0] from_lvl,
                                  input logic [NUM_INPUTS-1:0] to_lvl);
        time           change_time;
        int            k;
        logic [DW-1:0] rd;
        logic          seen;
        raw_in      = to_lvl;
        change_time = $time;
        seen        = 1'b0;
        do begin
            bus_read(debounce_pkg::reg_level, rd);
            k = int'(($time - change_time) / CLK_PERIOD) - 2; // Edge whose level the read shows
            if (rd === widen(to_lvl)) begin
                seen = 1'b1;
                assert (k >= SETTLE_MIN && k <= SETTLE_MAX) else begin
                    $display("FAIL %0t: level settled after %0d cycles, allowed %0d to %0d",
                             $time, k, SETTLE_MIN, SETTLE_MAX);
                    errors++;
                end
            end else begin
                check_word("level while settling", rd, widen(from_lvl));
            end
        end while (!seen && k <= SETTLE_MAX);
        if (!seen) begin
            $display("level 0x%0h never appeared after a steady input change", to_lvl);
            errors++;
        end
        wait_cycles(STABLE_COUNT + 2);
    endtask

    task automatic glitch_rejection();
        logic [31:0]           r;
        logic [NUM_INPUTS-1:0] mask;
        logic [DW-1:0]         rd;
        int                    len;
        int                    rail;
        int                    p;
        int                    j;
        start_test();
        for (rail = 0; rail < 2; rail++) begin
            if (rail == 1) begin
                r           = $random(seed);
                level_model = r[NUM_INPUTS-1:0] | NUM_INPUTS'(1);
                raw_in      = level_model;
                wait_cycles(SATURATE);
            end
            for (p = 0; p < NUM_PULSES; p++) begin
                r      = $random(seed);
                mask   = r[NUM_INPUTS-1:0];
                r      = $random(seed);
                len    = 1 + int'(r % (STABLE_COUNT / 2 - 1));
                raw_in = level_model ^ mask;
                wait_cycles(len);
                raw_in = level_model;
                for (j = 0; j < GLITCH_READS; j++) begin
                    bus_read(debounce_pkg::reg_level, rd);
                    check_word("level during glitch", rd, widen(level_model));
                end
            end
        end
        end_test("glitch_rejection");
    endtask

    task automatic settling();
        start_test();
        measure_settle(level_model, ~level_model);
        level_model = ~level_model;
        measure_settle(level_model, ~level_model);
        level_model = ~level_model;
        end_test("settling");
    endtask

    task automatic edge_events();
        logic [DW-1:0] rd;
        start_test();
        bus_read(debounce_pkg::reg_pending, rd);
        check_word("pending before edges", rd, '0);
        check_irq(1'b0);
        bus_write(debounce_pkg::reg_rise_en, widen(RISE_MASK));
        bus_write(debounce_pkg::reg_fall_en, widen(FALL_MASK));
        pending_model = (~level_model & RISE_MASK) | (level_model & FALL_MASK);
        measure_settle(level_model, ~level_model); // Every input toggles
        level_model = ~level_model;
        bus_read(debounce_pkg::reg_pending, rd);
        check_word("pending after edges", rd, widen(pending_model));
        check_irq(1'b1);
        end_test("edge_events");
    endtask

    task automatic write_one_to_clear();
        logic [31:0]           r;
        logic [NUM_INPUTS-1:0] mask;
        logic [DW-1:0]         rd;
        start_test();
        r    = $random(seed);
        mask = r[NUM_INPUTS-1:0] & ~KEEP_BIT;
        bus_write(debounce_pkg::reg_pending, widen(mask));
        pending_model = pending_model & ~mask;
        bus_read(debounce_pkg::reg_pending, rd);
        check_word("pending after partial clear", rd, widen(pending_model));
        check_irq(1'b1);
        bus_write(debounce_pkg::reg_pending, widen(pending_model));
        pending_model = '0;
        bus_read(debounce_pkg::reg_pending, rd);
        check_word("pending after full clear", rd, '0);
        check_irq(1'b0);
        end_test("write_one_to_clear");
    endtask

    task automatic bus_protocol();
        logic [DW-1:0] rd;
        int            acks;
        start_test();
        bus_read(debounce_pkg::reg_rise_en, rd);
        check_word("rise enable", rd, widen(RISE_MASK));
        bus_read(debounce_pkg::reg_fall_en, rd);
        check_word("fall enable", rd, widen(FALL_MASK));
        bus_write(debounce_pkg::reg_level, widen(~level_model));
        bus_read(debounce_pkg::reg_level, rd);
        check_word("level after write", rd, widen(level_model));
        acks   = 0;
        wb_cyc = 1'b1; // A held request is answered every second cycle
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = debounce_pkg::reg_level;
        repeat (HOLD_CYCLES) begin
            @(posedge clk);
            if (wb_ack) begin
                acks++;
            end
        end
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        assert (acks == HOLD_CYCLES / 2) else begin
            $display("FAIL %0t: held request got %0d acks, expected %0d",
                     $time, acks, HOLD_CYCLES / 2);
            errors++;
        end
        end_test("bus_protocol");
    endtask

    initial begin
        seed          = 32'h4bb5_8090;
        reset         = 1'b1;
        raw_in        = '0;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_dat_w      = '0;
        level_model   = '0;
        pending_model = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        glitch_rejection();
        settling();
        edge_events();
        write_one_to_clear();
        bus_protocol();
        $display("%0d tests run, %0d passed, %0d failed, %0d failed checks",
                 passed + failed, passed, failed, failure_total());
        if (failed == 0 && failure_total() == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verif/debounce_assertions.sv */
// Wishbone handshake and reset checks on debounce_top ports; fail_count totals the failed checks
module debounce_assertions (
    input logic clk,
    input logic reset,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic irq
);

    int late_ack_count   = 0;
    int double_ack_count = 0;
    int stray_ack_count  = 0;
    int reset_count      = 0;
    int fail_count;

    assign fail_count = late_ack_count + double_ack_count + stray_ack_count + reset_count;

    // A new request is one that is not being answered in this cycle
    a_ack_follows_req: assert property (@(posedge clk) disable iff (reset)
        (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
    else begin
        late_ack_count++;
        $error("ack missing in the cycle after a request");
    end

    a_ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack)
    else begin
        double_ack_count++;
        $error("ack high for two cycles in a row");
    end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> (wb_cyc && wb_stb))
    else begin
        stray_ack_count++;
        $error("ack high without cyc and stb");
    end

    a_quiet_after_reset: assert property (@(posedge clk)
        reset |=> (!wb_ack && !irq))
    else begin
        reset_count++;
        $error("ack or irq high in the cycle after reset");
    end

endmodule

bind debounce_top debounce_assertions u_checks (
    .clk    (clk),
    .reset  (reset),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack),
    .irq    (irq)
);

/* verilog/debounce_top.sv */
// Debounced input block; NUM_INPUTS at most 32, one STABLE_COUNT (even, >= 2) for all inputs
module debounce_top #(
    parameter int NUM_INPUTS   = 8,
    parameter int STABLE_COUNT = 8
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [NUM_INPUTS-1:0]               raw_in,   // Asynchronous, may bounce
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [debounce_pkg::addr_width-1:0] wb_adr,
    input  logic [debounce_pkg::data_width-1:0] wb_dat_w,
    output logic [debounce_pkg::data_width-1:0] wb_dat_r,
    output logic                                wb_ack,
    output logic                                irq
);

    logic [NUM_INPUTS-1:0] clean_level;

    event_cfg_if #(
        .NUM_INPUTS (NUM_INPUTS)
    ) cfg_bus ();

    debounce_bank #(
        .NUM_INPUTS   (NUM_INPUTS),
        .STABLE_COUNT (STABLE_COUNT)
    ) u_bank (
        .clk         (clk),
        .reset       (reset),
        .raw_in      (raw_in),
        .clean_level (clean_level)
    );

    wb_reg_slave #(
        .NUM_INPUTS (NUM_INPUTS)
    ) u_regs (
        .clk         (clk),
        .reset       (reset),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .clean_level (clean_level),
        .cfg         (cfg_bus.regs)
    );

    edge_event_unit #(
        .NUM_INPUTS (NUM_INPUTS)
    ) u_events (
        .clk         (clk),
        .reset       (reset),
        .clean_level (clean_level),
        .cfg         (cfg_bus.events),
        .irq         (irq)
    );

endmodule

/* verilog/edge_event_unit.sv */
// Sticky edge events on the clean levels; a new edge wins over a clear in the same cycle
module edge_event_unit #(
    parameter int NUM_INPUTS = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [NUM_INPUTS-1:0] clean_level,
    event_cfg_if.events           cfg,
    output logic                  irq
);

    logic [NUM_INPUTS-1:0] level_q;   // Clean level one cycle ago
    logic [NUM_INPUTS-1:0] rise;
    logic [NUM_INPUTS-1:0] fall;
    logic [NUM_INPUTS-1:0] set_bits;  // Enabled edges seen this cycle

    // Clean level is 0 out of reset, so the previous value starts there too
    always_ff @(posedge clk) begin
        if (reset) begin
            level_q <= '0;
        end else begin
            level_q <= clean_level;
        end
    end

    assign rise     = clean_level & ~level_q;
    assign fall     = ~clean_level & level_q;
    assign set_bits = (rise & cfg.rise_en) | (fall & cfg.fall_en);

    // Set after clear gives the edge priority
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg.pending <= '0;
        end else begin
            cfg.pending <= (cfg.pending & ~cfg.clear_mask) | set_bits;
        end
    end

    // Interrupt trails the pending bits by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            irq <= 1'b0;
        end else begin
            irq <= |cfg.pending;
        end
    end

endmodule

/* verilog/wb_reg_slave.sv */
// Wishbone classic slave; whole-word writes only, no byte selects and no error response
module wb_reg_slave #(
    parameter int NUM_INPUTS = 8
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic [debounce_pkg::addr_width-1:0] wb_adr,
    input  logic [debounce_pkg::data_width-1:0] wb_dat_w,
    output logic [debounce_pkg::data_width-1:0] wb_dat_r,
    output logic                                wb_ack,
    input  logic [NUM_INPUTS-1:0]               clean_level,
    event_cfg_if.regs                           cfg
);

    logic                                req;      // New request not yet answered
    logic                                wr_req;
    logic [NUM_INPUTS-1:0]               wr_bits;  // Write data cut to the input count
    logic [debounce_pkg::data_width-1:0] rd_word;
    logic [NUM_INPUTS-1:0]               rise_en_q;
    logic [NUM_INPUTS-1:0]               fall_en_q;

    // Skipping the cycle after ack makes a held request answer every second cycle
    assign req     = wb_cyc && wb_stb && !wb_ack;
    assign wr_req  = req && wb_we;
    assign wr_bits = wb_dat_w[NUM_INPUTS-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    // Enable registers
    always_ff @(posedge clk) begin
        if (reset) begin
            rise_en_q <= '0;
            fall_en_q <= '0;
        end else if (wr_req) begin
            if (wb_adr == debounce_pkg::reg_rise_en) begin
                rise_en_q <= wr_bits;
            end
            if (wb_adr == debounce_pkg::reg_fall_en) begin
                fall_en_q <= wr_bits;
            end
        end
    end

    // One-cycle clear strobe from a write to the pending register
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg.clear_mask <= '0;
        end else if (wr_req && wb_adr == debounce_pkg::reg_pending) begin
            cfg.clear_mask <= wr_bits;
        end else begin
            cfg.clear_mask <= '0;
        end
    end

    assign cfg.rise_en = rise_en_q;
    assign cfg.fall_en = fall_en_q;

    // Read mux, upper bits stay zero
    always_comb begin
        rd_word = '0;
        case (wb_adr)
            debounce_pkg::reg_level: begin
                rd_word[NUM_INPUTS-1:0] = clean_level;
            end
            debounce_pkg::reg_rise_en: begin
                rd_word[NUM_INPUTS-1:0] = rise_en_q;
            end
            debounce_pkg::reg_fall_en: begin
                rd_word[NUM_INPUTS-1:0] = fall_en_q;
            end
            default: begin
                rd_word[NUM_INPUTS-1:0] = cfg.pending;
            end
        endcase
    end

    // Read data is captured with the ack so it is stable while ack is high
    always_ff @(posedge clk) begin
        if (req && !wb_we) begin
            wb_dat_r <= rd_word;
        end
    end

endmodule

/* verilog/debounce_bank.sv */
// Two-flop synchronizer plus saturating integrator per input; STABLE_COUNT must be even and >= 2
module debounce_bank #(
    parameter int NUM_INPUTS   = 8,
    parameter int STABLE_COUNT = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [NUM_INPUTS-1:0] raw_in,
    output logic [NUM_INPUTS-1:0] clean_level
);

    localparam int CNT_WIDTH = $clog2(STABLE_COUNT + 1);
    localparam logic [CNT_WIDTH-1:0] CNT_MAX   = CNT_WIDTH'(STABLE_COUNT);
    localparam logic [CNT_WIDTH-1:0] THRESHOLD = CNT_WIDTH'(STABLE_COUNT / 2);

    logic [NUM_INPUTS-1:0] sync_meta; // First stage, may go metastable
    logic [NUM_INPUTS-1:0] sync_out;  // Filter input

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_meta <= '0;
            sync_out  <= '0;
        end else begin
            sync_meta <= raw_in;
            sync_out  <= sync_meta;
        end
    end

    genvar i;
    generate
        for (i = 0; i < NUM_INPUTS; i++) begin : g_filter
            logic [CNT_WIDTH-1:0] cnt;
            logic [CNT_WIDTH-1:0] cnt_next;

            // Integrate up on 1 and down on 0, stopping at either rail
            always_comb begin
                cnt_next = cnt;
                if (sync_out[i] && cnt < CNT_MAX) begin
                    cnt_next = cnt + 1'b1;
                end else if (!sync_out[i] && cnt != '0) begin
                    cnt_next = cnt - 1'b1;
                end
            end

            // The level is a registered compare of the count, one cycle behind it
            always_ff @(posedge clk) begin
                if (reset) begin
                    cnt            <= '0;
                    clean_level[i] <= 1'b0;
                end else begin
                    cnt            <= cnt_next;
                    clean_level[i] <= (cnt >= THRESHOLD);
                end
            end
        end
    endgenerate

endmodule

/* verilog/event_cfg_if.sv */
// Configuration and status between register slave and event unit; clear_mask is a 1-cycle strobe
interface event_cfg_if #(
    parameter int NUM_INPUTS = 8
);

    logic [NUM_INPUTS-1:0] rise_en;    // Per-input rising edge enable
    logic [NUM_INPUTS-1:0] fall_en;    // Per-input falling edge enable
    logic [NUM_INPUTS-1:0] clear_mask; // Strobe, each set bit clears that pending bit
    logic [NUM_INPUTS-1:0] pending;    // Sticky edge events

    // Register side owns the configuration and the clear strobe
    modport regs (
        output rise_en,
        output fall_en,
        output clear_mask,
        input  pending
    );

    // Event side owns the pending state
    modport events (
        input  rise_en,
        input  fall_en,
        input  clear_mask,
        output pending
    );

endinterface

/* verilog/debounce_pkg.sv */
// Bus widths and register word addresses; the slave decodes word addresses only, not bytes
package debounce_pkg;

    // Wishbone data word width
    localparam int data_width = 32;

    // Width of the word address decoded by the register slave
    localparam int addr_width = 2;

    // Register map, one word per register
    localparam logic [addr_width-1:0] reg_level   = 2'd0; // Clean levels, read only
    localparam logic [addr_width-1:0] reg_rise_en = 2'd1; // Rising edge enables
    localparam logic [addr_width-1:0] reg_fall_en = 2'd2; // Falling edge enables
    localparam logic [addr_width-1:0] reg_pending = 2'd3; // Pending bits, write one to clear

endpackage
